// File: src/link_pkg.sv
// receive-side definitions: frame layout, link timing and copy FSM states
`default_nettype none

package link_pkg;

    // --------------------
    // frame geometry
    // --------------------
    localparam int unsigned FRAME_WORDS = 64;        // words per frame = buffer depth
    typedef logic [$clog2(FRAME_WORDS)-1:0] frame_addr_t;
    typedef logic [31:0] link_word_t;

    // word groups, selected by the upper three address bits
    localparam logic [2:0] POS_GROUP = 3'd1;         // 0x08..0x0f, slot 0 unused
    localparam logic [2:0] POT_GROUP = 3'd2;         // 0x10..0x17

    // status words live in the group after the pots
    localparam frame_addr_t SWITCH_WORD        = {POT_GROUP + 3'd1, 3'd1};
    localparam frame_addr_t ESII_WORD          = {POT_GROUP + 3'd1, 3'd2};
    localparam frame_addr_t INST_MODEL_WORD    = {POT_GROUP + 3'd1, 3'd4};
    localparam frame_addr_t INST_ID_WORD       = {POT_GROUP + 3'd1, 3'd5};
    localparam frame_addr_t PRELOAD_VALID_WORD = {POT_GROUP + 3'd1, 3'd7}; // bit 0 only

    // --------------------
    // link watchdog
    // --------------------
    // kept short so a few frames fit in one window in simulation
    localparam int unsigned WDOG_WINDOW_CYCLES = 2000;
    localparam int unsigned WDOG_CNT_W = $clog2(WDOG_WINDOW_CYCLES);

    // copy from pre-check buffer to main buffer
    typedef enum logic {
        COPY_IDLE,
        COPY_RUN
    } copy_state_e;

endpackage

`default_nettype wire

// File: src/regmap_pkg.sv
// host register map: address spaces, offsets, encoder constants and fill values
`default_nettype none

package regmap_pkg;

    typedef logic [15:0] reg_addr_t;   // host bus address
    typedef logic [31:0] reg_data_t;   // host bus data

    // upper address nibble picks the space
    typedef enum logic [3:0] {
        SPACE_MAIN  = 4'h0,            // per-channel registers, channel in bits 7:4
        SPACE_BOARD = 4'hB,            // board specific
        SPACE_ESPM  = 4'hC             // raw received words, bits 5:0
    } space_e;

    // --------------------
    // encoders
    // --------------------
    localparam int unsigned ENC_CHANNELS = 7;
    typedef logic [23:0] enc_count_t;
    localparam enc_count_t ENC_MIDRANGE = 24'h800000;  // preload after reset

    // main space offsets, address bits 3:0
    localparam logic [3:0] OFF_ENC_LOAD = 4'h4;
    localparam logic [3:0] OFF_ENC_DATA = 4'h5;

    // --------------------
    // board specific space
    // --------------------
    localparam logic [11:0] BS_CRC_ERR    = 12'h000;
    localparam logic [11:0] BS_CRC_GOOD   = 12'h001;
    localparam logic [11:0] BS_ESII       = 12'h010;
    localparam logic [11:0] BS_INST_MODEL = 12'h012;
    localparam logic [11:0] BS_INST_ID    = 12'h013;
    localparam logic [11:0] BS_SWITCH     = 12'h021;
    localparam logic [11:0] BS_BUILD      = 12'hfff;

    localparam reg_data_t FILL_WORD    = 32'h0000cccc; // any unmapped address
    localparam reg_data_t BUILD_NUMBER = 32'h00000100;

endpackage

`default_nettype wire

// File: src/espm_status_if.sv
// status words picked out of each copied frame, frame buffer to read mux
`timescale 1ns/1ns
`default_nettype none

interface espm_status_if;

    logic [31:0] switch_word;      // buttons on the module
    logic [31:0] esii_word;        // esii/escc link status
    logic [31:0] inst_model_word;  // instrument model
    logic [31:0] inst_id_word;     // instrument id
    logic        preload_good;     // module still holds our preload

    modport source (
        output switch_word, esii_word, inst_model_word, inst_id_word, preload_good
    );

    modport sink (
        input switch_word, esii_word, inst_model_word, inst_id_word, preload_good
    );

endinterface

`default_nettype wire

// File: src/espm_frame_buffer.sv
// receive buffers: pre-check store, copy on crc good, position and status extraction
`timescale 1ns/1ns
`default_nettype none

module espm_frame_buffer (
    input  wire                      sysclk,
    input  wire                      rst_n_i,
    input  wire                      rx_word_valid_i,
    input  wire link_pkg::frame_addr_t rx_word_addr_i,
    input  wire link_pkg::link_word_t  rx_word_data_i,
    input  wire                      rx_crc_good_i,
    input  wire                      buffer_hold_i,    // host block read in progress
    espm_status_if.source            status_o,
    output logic                     pos_valid_o,      // one cycle per position word
    output logic [2:0]               pos_index_o,      // channel 1..7
    output link_pkg::link_word_t     pos_data_o,
    input  wire link_pkg::frame_addr_t buf_raddr_i,
    output link_pkg::link_word_t     buf_rdata_o
);

    import link_pkg::*;

    link_word_t              pre_mem  [FRAME_WORDS];  // raw words, crc not yet known
    link_word_t              main_mem [FRAME_WORDS];  // last accepted frame
    logic [FRAME_WORDS-1:0]  main_written;            // unwritten words read as zero
    copy_state_e             copy_state;
    frame_addr_t             rd_addr;                 // pre-check read pointer
    frame_addr_t             cp_addr;                 // write address, one stage behind
    link_word_t              cp_data;
    logic                    cp_we;

    // --------------------
    // pre-check buffer
    // --------------------
    always_ff @(posedge sysclk) begin
        if (rx_word_valid_i) begin
            pre_mem[rx_word_addr_i] <= rx_word_data_i;
        end
    end

    // --------------------
    // copy FSM
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            copy_state <= COPY_IDLE;
            rd_addr    <= '0;
            cp_we      <= 1'b0;
        end else begin
            cp_we <= (copy_state == COPY_RUN);   // write lags the read by one
            case (copy_state)
                COPY_IDLE: begin
                    // pulses under hold are dropped, frame is lost
                    if (rx_crc_good_i && !buffer_hold_i) begin
                        copy_state <= COPY_RUN;
                        rd_addr    <= '0;
                    end
                end
                COPY_RUN: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == frame_addr_t'(FRAME_WORDS - 1)) begin
                        copy_state <= COPY_IDLE;  // last read issued
                    end
                end
                default: copy_state <= COPY_IDLE;
            endcase
        end
    end

    // copy datapath and host read port
    always_ff @(posedge sysclk) begin
        cp_data <= pre_mem[rd_addr];
        cp_addr <= rd_addr;
        if (cp_we) begin
            main_mem[cp_addr] <= cp_data;
        end
        buf_rdata_o <= main_written[buf_raddr_i] ? main_mem[buf_raddr_i] : '0;
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_written <= '0;
        end else if (cp_we) begin
            main_written[cp_addr] <= 1'b1;
        end
    end

    // --------------------
    // extraction during copy
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pos_valid_o              <= 1'b0;
            status_o.switch_word     <= '0;
            status_o.esii_word       <= '0;
            status_o.inst_model_word <= '0;
            status_o.inst_id_word    <= '0;
            status_o.preload_good    <= 1'b0;
        end else begin
            // slot 0 of the position group carries no encoder
            pos_valid_o <= cp_we && (cp_addr[5:3] == POS_GROUP) && (cp_addr[2:0] != 3'd0);
            if (cp_we) begin
                case (cp_addr)
                    SWITCH_WORD:        status_o.switch_word     <= cp_data;
                    ESII_WORD:          status_o.esii_word       <= cp_data;
                    INST_MODEL_WORD:    status_o.inst_model_word <= cp_data;
                    INST_ID_WORD:       status_o.inst_id_word    <= cp_data;
                    PRELOAD_VALID_WORD: status_o.preload_good    <= cp_data[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk) begin
        pos_index_o <= cp_addr[2:0];
        pos_data_o  <= cp_data;
    end

endmodule

`default_nettype wire

// File: src/encoder_preload_channel.sv
// one encoder channel: host preload kept as offset against the received position
`timescale 1ns/1ns
`default_nettype none

module encoder_preload_channel #(
    parameter int unsigned CHANNEL = 1        // 1..7, matches pos_index_i
) (
    input  wire                       sysclk,
    input  wire                       rst_n_i,
    input  wire                       reg_wen_i,
    input  wire regmap_pkg::reg_addr_t reg_waddr_i,
    input  wire regmap_pkg::reg_data_t reg_wdata_i,
    input  wire                       pos_valid_i,
    input  wire [2:0]                 pos_index_i,
    input  wire link_pkg::link_word_t pos_data_i,
    output regmap_pkg::enc_count_t    preload_o,
    output regmap_pkg::enc_count_t    count_o,
    output logic                      overflow_o
);

    import regmap_pkg::*;

    enc_count_t position;     // raw count from the module
    enc_count_t offset;       // preload minus position at load time
    logic       load_hit;
    logic       near_end;     // count close to either end of range

    // preload write aimed at this channel
    assign load_hit = reg_wen_i
                   && (reg_waddr_i[15:12] == SPACE_MAIN)
                   && (reg_waddr_i[7:4] == 4'(CHANNEL))
                   && (reg_waddr_i[3:0] == OFF_ENC_LOAD);

    assign count_o  = position + offset;   // wraps mod 2^24
    assign near_end = (count_o[23:12] == 12'h000) || (count_o[23:12] == 12'hfff);

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            position   <= '0;
            preload_o  <= ENC_MIDRANGE;
            offset     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (pos_valid_i && (pos_index_i == 3'(CHANNEL))) begin
                position <= pos_data_i[23:0];
            end
            if (load_hit) begin
                preload_o  <= reg_wdata_i[23:0];
                offset     <= reg_wdata_i[23:0] - position;
                overflow_o <= 1'b0;         // new preload, fresh start
            end else if (near_end) begin
                overflow_o <= 1'b1;         // sticky until next preload
            end
        end
    end

endmodule

`default_nettype wire

// File: src/link_monitor.sv
// link health: good and bad frame counters plus the no-good-frame watchdog
`timescale 1ns/1ns
`default_nettype none

module link_monitor (
    input  wire                    sysclk,
    input  wire                    rst_n_i,
    input  wire                    rx_frame_end_i,
    input  wire                    rx_crc_good_i,
    output regmap_pkg::reg_data_t  crc_good_count_o,
    output regmap_pkg::reg_data_t  crc_err_count_o,
    output logic                   comm_good_o
);

    import link_pkg::*;
    import regmap_pkg::*;

    logic [WDOG_CNT_W-1:0] win_cnt;
    logic                  win_end;
    reg_data_t             good_at_last_end;  // good count at previous window end

    assign win_end = (win_cnt == WDOG_CNT_W'(WDOG_WINDOW_CYCLES - 1));

    // --------------------
    // frame counters
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crc_good_count_o <= '0;
            crc_err_count_o  <= '0;
        end else begin
            if (rx_crc_good_i) begin
                crc_good_count_o <= crc_good_count_o + 1'b1;
            end
            if (rx_frame_end_i && !rx_crc_good_i) begin
                crc_err_count_o <= crc_err_count_o + 1'b1;  // end without crc good
            end
        end
    end

    // --------------------
    // watch window
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            win_cnt          <= '0;
            good_at_last_end <= '0;
            comm_good_o      <= 1'b0;
        end else if (win_end) begin
            win_cnt          <= '0;
            good_at_last_end <= crc_good_count_o;
            comm_good_o      <= (crc_good_count_o != good_at_last_end);  // any good frame
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_read_mux.sv
// host read data: registered selection across main, board-specific and espm spaces
`timescale 1ns/1ns
`default_nettype none

module reg_read_mux (
    input  wire                        sysclk,
    input  wire                        rst_n_i,
    input  wire regmap_pkg::reg_addr_t reg_raddr_i,
    espm_status_if.sink                status_i,
    input  wire regmap_pkg::enc_count_t preload_i  [1:regmap_pkg::ENC_CHANNELS],
    input  wire regmap_pkg::enc_count_t count_i    [1:regmap_pkg::ENC_CHANNELS],
    input  wire [1:regmap_pkg::ENC_CHANNELS] overflow_i,
    input  wire regmap_pkg::reg_data_t crc_good_count_i,
    input  wire regmap_pkg::reg_data_t crc_err_count_i,
    output link_pkg::frame_addr_t      buf_raddr_o,
    input  wire link_pkg::link_word_t  buf_rdata_i,
    output regmap_pkg::reg_data_t      reg_rdata_o
);

    import link_pkg::*;
    import regmap_pkg::*;

    logic [3:0] chan;        // main space channel
    logic       chan_ok;
    reg_data_t  rdata_q;     // all spaces except espm
    logic       espm_sel_q;  // buffer already registers its own read

    assign chan        = reg_raddr_i[7:4];
    assign chan_ok     = (chan != 4'd0) && (chan <= 4'(ENC_CHANNELS));
    assign buf_raddr_o = reg_raddr_i[5:0];

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q    <= '0;
            espm_sel_q <= 1'b0;
        end else begin
            espm_sel_q <= (reg_raddr_i[15:12] == SPACE_ESPM);
            case (space_e'(reg_raddr_i[15:12]))
                // --------------------
                SPACE_MAIN: begin
                    if (chan_ok && (reg_raddr_i[3:0] == OFF_ENC_LOAD)) begin
                        rdata_q <= {8'h00, preload_i[chan]};
                    end else if (chan_ok && (reg_raddr_i[3:0] == OFF_ENC_DATA)) begin
                        rdata_q <= {7'b0, overflow_i[chan], count_i[chan]};  // flag in bit 24
                    end else begin
                        rdata_q <= FILL_WORD;
                    end
                end
                // --------------------
                SPACE_BOARD: begin
                    case (reg_raddr_i[11:0])
                        BS_CRC_ERR:    rdata_q <= crc_err_count_i;
                        BS_CRC_GOOD:   rdata_q <= crc_good_count_i;
                        BS_ESII:       rdata_q <= status_i.esii_word;
                        BS_INST_MODEL: rdata_q <= status_i.inst_model_word;
                        BS_INST_ID:    rdata_q <= status_i.inst_id_word;
                        BS_SWITCH:     rdata_q <= status_i.switch_word;
                        BS_BUILD:      rdata_q <= BUILD_NUMBER;
                        default:       rdata_q <= FILL_WORD;
                    endcase
                end
                default: rdata_q <= FILL_WORD;  // espm space overridden below
            endcase
        end
    end

    // both paths are registers, so data is valid one cycle after the address
    assign reg_rdata_o = espm_sel_q ? buf_rdata_i : rdata_q;

endmodule

`default_nettype wire

// File: src/espm_bridge_top.sv
// encoder-module link top: frame buffer, seven encoder channels, link monitor and read mux
`timescale 1ns/1ns
`default_nettype none

module espm_bridge_top (
    input  wire                        sysclk,
    input  wire                        rst_n_i,
    // receiver side, already in sysclk
    input  wire                        rx_word_valid_i,
    input  wire link_pkg::frame_addr_t rx_word_addr_i,
    input  wire link_pkg::link_word_t  rx_word_data_i,
    input  wire                        rx_frame_end_i,
    input  wire                        rx_crc_good_i,
    // host side
    input  wire                        reg_wen_i,
    input  wire regmap_pkg::reg_addr_t reg_waddr_i,
    input  wire regmap_pkg::reg_data_t reg_wdata_i,
    input  wire regmap_pkg::reg_addr_t reg_raddr_i,
    output regmap_pkg::reg_data_t      reg_rdata_o,
    input  wire                        buffer_hold_i,
    // status
    output logic                       comm_good_o,
    output logic                       interlock_ok_o
);

    import link_pkg::*;
    import regmap_pkg::*;

    espm_status_if status_if ();

    logic        pos_valid;
    logic [2:0]  pos_index;
    link_word_t  pos_data;
    frame_addr_t buf_raddr;
    link_word_t  buf_rdata;
    enc_count_t  enc_preload [1:ENC_CHANNELS];
    enc_count_t  enc_count   [1:ENC_CHANNELS];
    logic [1:ENC_CHANNELS] enc_overflow;
    reg_data_t   crc_good_count;
    reg_data_t   crc_err_count;

    espm_frame_buffer u_espm_frame_buffer (
        .sysclk          (sysclk),
        .rst_n_i         (rst_n_i),
        .rx_word_valid_i (rx_word_valid_i),
        .rx_word_addr_i  (rx_word_addr_i),
        .rx_word_data_i  (rx_word_data_i),
        .rx_crc_good_i   (rx_crc_good_i),
        .buffer_hold_i   (buffer_hold_i),
        .status_o        (status_if.source),
        .pos_valid_o     (pos_valid),
        .pos_index_o     (pos_index),
        .pos_data_o      (pos_data),
        .buf_raddr_i     (buf_raddr),
        .buf_rdata_o     (buf_rdata)
    );

    // --------------------
    // encoder channels 1..7
    // --------------------
    for (genvar ch = 1; ch <= ENC_CHANNELS; ch++) begin : g_enc
        encoder_preload_channel #(.CHANNEL(ch)) u_enc (
            .sysclk      (sysclk),
            .rst_n_i     (rst_n_i),
            .reg_wen_i   (reg_wen_i),
            .reg_waddr_i (reg_waddr_i),
            .reg_wdata_i (reg_wdata_i),
            .pos_valid_i (pos_valid),
            .pos_index_i (pos_index),
            .pos_data_i  (pos_data),
            .preload_o   (enc_preload[ch]),
            .count_o     (enc_count[ch]),
            .overflow_o  (enc_overflow[ch])
        );
    end

    link_monitor u_link_monitor (
        .sysclk           (sysclk),
        .rst_n_i          (rst_n_i),
        .rx_frame_end_i   (rx_frame_end_i),
        .rx_crc_good_i    (rx_crc_good_i),
        .crc_good_count_o (crc_good_count),
        .crc_err_count_o  (crc_err_count),
        .comm_good_o      (comm_good_o)
    );

    reg_read_mux u_reg_read_mux (
        .sysclk           (sysclk),
        .rst_n_i          (rst_n_i),
        .reg_raddr_i      (reg_raddr_i),
        .status_i         (status_if.sink),
        .preload_i        (enc_preload),
        .count_i          (enc_count),
        .overflow_i       (enc_overflow),
        .crc_good_count_i (crc_good_count),
        .crc_err_count_i  (crc_err_count),
        .buf_raddr_o      (buf_raddr),
        .buf_rdata_i      (buf_rdata),
        .reg_rdata_o      (reg_rdata_o)
    );

    // motors may run only with a live link and a valid preload
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            interlock_ok_o <= 1'b0;
        end else begin
            interlock_ok_o <= comm_good_o && status_if.preload_good;
        end
    end

endmodule

`default_nettype wire

// File: testbench/espm_bridge_checker.sv
// testbench checker: models buffer and link status from the DUT inputs, compares host reads
`timescale 1ns/1ns
`default_nettype none

module espm_bridge_checker (
    input  wire                        sysclk,
    input  wire                        rst_n_i,
    input  wire                        rx_word_valid_i,
    input  wire link_pkg::frame_addr_t rx_word_addr_i,
    input  wire link_pkg::link_word_t  rx_word_data_i,
    input  wire                        rx_crc_good_i,
    input  wire                        buffer_hold_i,
    input  wire [31:0]                 reg_rdata_i,
    input  wire                        comm_good_i,
    input  wire                        interlock_ok_i
);

    import link_pkg::*;

    int unsigned checks;          // compares done
    int unsigned value_errors;    // compares that failed

    link_word_t  pre_m  [FRAME_WORDS];   // expected pre-check buffer
    link_word_t  main_m [FRAME_WORDS];   // expected main buffer
    int unsigned busy_m;                 // cycles left before a new copy is taken
    int unsigned good_m;                 // good frames so far
    int unsigned good_last_m;            // good frames at last window end
    int unsigned win_m;
    logic        comm_m;
    logic        pg_m;                   // preload valid of last copied frame
    logic        ilk_m;

    initial begin
        checks       = 0;
        value_errors = 0;
    end

    // --------------------
    // reference model
    // --------------------
    always @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FRAME_WORDS; i++) begin
                main_m[i] = '0;          // nothing copied yet
            end
            busy_m      = 0;
            good_m      = 0;
            good_last_m = 0;
            win_m       = 0;
            comm_m      = 1'b0;
            pg_m        = 1'b0;
            ilk_m       = 1'b0;
        end else begin
            ilk_m = comm_m && pg_m;      // uses values from before this edge
            if (win_m == WDOG_WINDOW_CYCLES - 1) begin
                comm_m      = (good_m != good_last_m);
                good_last_m = good_m;
                win_m       = 0;
            end else begin
                win_m = win_m + 1;
            end
            if (rx_word_valid_i) begin
                pre_m[rx_word_addr_i] = rx_word_data_i;
            end
            if (busy_m != 0) begin
                busy_m = busy_m - 1;
            end
            if (rx_crc_good_i) begin
                good_m = good_m + 1;
                // frame is lost under hold or while a copy runs
                if (!buffer_hold_i && busy_m == 0) begin
                    for (int i = 0; i < FRAME_WORDS; i++) begin
                        main_m[i] = pre_m[i];
                    end
                    pg_m   = pre_m[PRELOAD_VALID_WORD][0];
                    busy_m = FRAME_WORDS + 1;
                end
            end
        end
    end

    // --------------------
    // compares
    // --------------------
    // espm words come from the model, everything else from the tests file
    task automatic check_read(input logic [8*24-1:0] tname, input logic [15:0] addr,
                              input bit from_model, input logic [31:0] exp_file);
        logic [31:0] expected;
        expected = from_model ? main_m[addr[5:0]] : exp_file;
        checks   = checks + 1;
        if (reg_rdata_i !== expected) begin
            value_errors = value_errors + 1;
            $display("error %0s: read %04h expected %08h actual %08h",
                     tname, addr, expected, reg_rdata_i);
        end
    endtask

    task automatic check_link(input logic [8*24-1:0] tname);
        checks = checks + 2;
        if (comm_good_i !== comm_m) begin
            value_errors = value_errors + 1;
            $display("error %0s: comm_good_o expected %0b actual %0b",
                     tname, comm_m, comm_good_i);
        end
        if (interlock_ok_i !== ilk_m) begin
            value_errors = value_errors + 1;
            $display("error %0s: interlock_ok_o expected %0b actual %0b",
                     tname, ilk_m, interlock_ok_i);
        end
    endtask

endmodule

`default_nettype wire

// File: testbench/tb_espm_bridge.sv
// testbench top: clock, reset and a command engine that runs the lines of the tests file
`timescale 1ns/1ns
`default_nettype none

module tb_espm_bridge;

    import link_pkg::*;
    import regmap_pkg::*;

    localparam int unsigned COPY_WAIT   = 70;   // copy ends 66 cycles after crc good
    localparam int unsigned WIN_TIMEOUT = 3 * WDOG_WINDOW_CYCLES;

    logic        sysclk;
    logic        rst_n;
    logic        rx_word_valid;
    frame_addr_t rx_word_addr;
    link_word_t  rx_word_data;
    logic        rx_frame_end;
    logic        rx_crc_good;
    logic        reg_wen;
    reg_addr_t   reg_waddr;
    reg_data_t   reg_wdata;
    reg_addr_t   reg_raddr;
    reg_data_t   reg_rdata;
    logic        buffer_hold;
    logic        comm_good;
    logic        interlock_ok;

    link_word_t  word_value [FRAME_WORDS];  // words pinned by the tests file
    logic        word_fixed [FRAME_WORDS];  // others are random filler
    int unsigned other_errors;

    always #5 sysclk = ~sysclk;

    espm_bridge_top u_espm_bridge_top (
        .sysclk          (sysclk),
        .rst_n_i         (rst_n),
        .rx_word_valid_i (rx_word_valid),
        .rx_word_addr_i  (rx_word_addr),
        .rx_word_data_i  (rx_word_data),
        .rx_frame_end_i  (rx_frame_end),
        .rx_crc_good_i   (rx_crc_good),
        .reg_wen_i       (reg_wen),
        .reg_waddr_i     (reg_waddr),
        .reg_wdata_i     (reg_wdata),
        .reg_raddr_i     (reg_raddr),
        .reg_rdata_o     (reg_rdata),
        .buffer_hold_i   (buffer_hold),
        .comm_good_o     (comm_good),
        .interlock_ok_o  (interlock_ok)
    );

    espm_bridge_checker u_espm_bridge_checker (
        .sysclk          (sysclk),
        .rst_n_i         (rst_n),
        .rx_word_valid_i (rx_word_valid),
        .rx_word_addr_i  (rx_word_addr),
        .rx_word_data_i  (rx_word_data),
        .rx_crc_good_i   (rx_crc_good),
        .buffer_hold_i   (buffer_hold),
        .reg_rdata_i     (reg_rdata),
        .comm_good_i     (comm_good),
        .interlock_ok_i  (interlock_ok)
    );

    // --------------------
    // bus tasks
    // --------------------
    task automatic idle_cycles(input int unsigned n);
        for (int unsigned k = 0; k < n; k++) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    // 64 words, then the end pulse, then time for the copy
    task automatic send_frame(input logic crc_ok);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            rx_word_valid = 1'b1;
            rx_word_addr  = frame_addr_t'(i);
            rx_word_data  = word_fixed[i] ? word_value[i] : $urandom;
            @(posedge sysclk);
            #1;
        end
        rx_word_valid = 1'b0;
        rx_frame_end  = 1'b1;
        rx_crc_good   = crc_ok;                 // no pulse for a bad crc
        @(posedge sysclk);
        #1;
        rx_frame_end  = 1'b0;
        rx_crc_good   = 1'b0;
        idle_cycles(COPY_WAIT);
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(posedge sysclk);
        #1;
        reg_wen = 1'b0;
        idle_cycles(1);                         // overflow flag follows the load
    endtask

    task automatic host_read(input logic [8*24-1:0] tname, input reg_addr_t addr,
                             input bit from_model, input reg_data_t expected);
        reg_raddr = addr;
        @(posedge sysclk);                      // address registered here
        @(negedge sysclk);
        u_espm_bridge_checker.check_read(tname, addr, from_model, expected);
        u_espm_bridge_checker.check_link(tname);   // link outputs on every read too
        @(posedge sysclk);
        #1;
    endtask

    task automatic wait_link(input logic [8*24-1:0] tname, input logic level);
        int unsigned cycles;
        cycles = 0;
        while (comm_good !== level && cycles < WIN_TIMEOUT) begin
            @(posedge sysclk);
            #1;
            cycles++;
        end
        if (comm_good !== level) begin
            other_errors++;
            $display("%0s: comm_good_o did not reach %0b within %0d cycles",
                     tname, level, WIN_TIMEOUT);
        end
        idle_cycles(2);                         // interlock lags by a register
        @(negedge sysclk);
        u_espm_bridge_checker.check_link(tname);
        @(posedge sysclk);
        #1;
    endtask

    // --------------------
    // command engine
    // --------------------
    task automatic run_command(input logic [8*24-1:0] tname, input logic [8*12-1:0] cmd,
                               input logic [31:0] arg1, input logic [31:0] arg2);
        if (cmd == "set") begin
            word_fixed[arg1[5:0]] = 1'b1;
            word_value[arg1[5:0]] = arg2;
        end else if (cmd == "frame") begin
            send_frame(1'b1);
        end else if (cmd == "badframe") begin
            send_frame(1'b0);
        end else if (cmd == "hold") begin
            buffer_hold = arg1[0];
            idle_cycles(1);
        end else if (cmd == "write") begin
            host_write(arg1[15:0], arg2);
        end else if (cmd == "read") begin
            host_read(tname, arg1[15:0], 1'b0, arg2);
        end else if (cmd == "readbuf") begin
            for (int i = 0; i < FRAME_WORDS; i++) begin
                host_read(tname, {SPACE_ESPM, 6'd0, 6'(i)}, 1'b1, '0);
            end
        end else if (cmd == "waitwin") begin
            wait_link(tname, arg1[0]);
        end else begin
            other_errors++;
            $display("%0s: unknown command %0s in the tests file", tname, cmd);
        end
    endtask

    initial begin
        int               fd;
        int               code;
        int               n;
        int unsigned      seed;
        logic [8*160-1:0] line;
        logic [8*24-1:0]  tname;
        logic [8*12-1:0]  cmd;
        logic [31:0]      arg1;
        logic [31:0]      arg2;

        sysclk        = 1'b0;
        rst_n         = 1'b0;
        rx_word_valid = 1'b0;
        rx_word_addr  = '0;
        rx_word_data  = '0;
        rx_frame_end  = 1'b0;
        rx_crc_good   = 1'b0;
        reg_wen       = 1'b0;
        reg_waddr     = '0;
        reg_wdata     = '0;
        reg_raddr     = '0;
        buffer_hold   = 1'b0;
        other_errors  = 0;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            word_fixed[i] = 1'b0;
            word_value[i] = '0;
        end
        seed = $urandom(10);                    // fixed seed for the filler words

        fd = $fopen("testbench/espm_bridge_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open testbench/espm_bridge_tests.txt");
        end

        repeat (8) @(posedge sysclk);
        #1;
        rst_n = 1'b1;

        while (fd != 0 && !$feof(fd)) begin
            line  = '0;
            tname = '0;
            code  = $fgets(line, fd);
            n     = $sscanf(line, "%s %s %h %h", tname, cmd, arg1, arg2);
            if (code == 0 || n < 1 || tname == "#") begin
                continue;                       // blank or comment line
            end else if (n != 4) begin
                other_errors++;
                $display("malformed line in the tests file: %0s", line);
            end else begin
                run_command(tname, cmd, arg1, arg2);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 u_espm_bridge_checker.checks, u_espm_bridge_checker.value_errors,
                 other_errors);
        if (u_espm_bridge_checker.value_errors == 0 && other_errors == 0
                && u_espm_bridge_checker.checks != 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: espm_bridge_top.f
src/link_pkg.sv
src/regmap_pkg.sv
src/espm_status_if.sv
src/espm_frame_buffer.sv
src/encoder_preload_channel.sv
src/link_monitor.sv
src/reg_read_mux.sv
src/espm_bridge_top.sv
testbench/espm_bridge_checker.sv
testbench/tb_espm_bridge.sv

// File: testbench/espm_bridge_tests.txt
# columns: test_name command arg1 arg2, args in hex and 0 when unused
# set pins a frame word (addr data), read compares (addr expected), readbuf uses the model
reset_state waitwin 0 0
reset_state read 0014 00800000
reset_state read b000 0
reset_state read b001 0
reset_state readbuf 0 0
unmapped read a000 0000cccc
build read bfff 00000100
setup set 09 00000100
setup set 0a 00000010
setup set 19 00000a5a
setup set 1a 0000e511
setup set 1c 00003c7b
setup set 1d 00001234
setup set 1f 00000001
good_frame frame 0 0
good_frame readbuf 0 0
good_frame read b021 00000a5a
good_frame read b010 0000e511
good_frame read b012 00003c7b
good_frame read b013 00001234
good_frame read b001 1
bad_frame badframe 0 0
bad_frame readbuf 0 0
bad_frame read b000 1
bad_frame read b001 1
hold_frame hold 1 0
hold_frame set 19 000005a5
hold_frame frame 0 0
hold_frame readbuf 0 0
hold_frame read b021 00000a5a
hold_frame hold 0 0
hold_frame frame 0 0
hold_frame readbuf 0 0
hold_frame read b021 000005a5
hold_frame read b001 3
preload write 0014 00123456
preload read 0014 00123456
preload read 0015 00123456
preload set 09 00000300
preload frame 0 0
preload read 0015 00123656
preload read 0014 00123456
overflow read 0025 01000010
overflow write 0024 00400000
overflow read 0025 00400000
overflow write 0024 00fff000
overflow read 0025 01fff000
overflow write 0024 00400000
overflow read 0025 00400000
link_up waitwin 1 0
link_up set 1f 00000000
link_up frame 0 0
link_up waitwin 1 0
link_down waitwin 0 0
